// File: memSubsystem_defs.svh
`ifndef MEM_SUBSYSTEM_DEFS_SVH
`define MEM_SUBSYSTEM_DEFS_SVH

// byte address width, 1024 bytes of RAM
`define MEM_ADDR_BITS 10

`define MEM_DEPTH (1 << `MEM_ADDR_BITS)

// rename tag carried by load/store requests
`define TAG_BITS 4

`define BYTE_BITS 8

// one fetch or full-word access
`define WORD_BYTES 4

`define WORD_BITS (`WORD_BYTES * `BYTE_BITS)

`endif

// File: memPkg.sv
`default_nettype none
`include "memSubsystem_defs.svh"

package memPkg;

    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2
    } accLen_e;

    // the ports see a word, the controller fills it lane by lane
    typedef union packed {
        logic [`WORD_BITS-1:0] word;
        logic [`WORD_BYTES-1:0][`BYTE_BITS-1:0] lane;
    } dataWord_u;

    typedef struct packed {
        logic store;
        logic [`MEM_ADDR_BITS-1:0] addr;
        accLen_e len;
        dataWord_u data;
    } memReq_s;

    typedef struct packed {
        memReq_s mem;
        logic [`TAG_BITS-1:0] tag;
    } lsuReq_s;

    typedef struct packed {
        logic [`TAG_BITS-1:0] tag;
        dataWord_u data;
    } lsuResp_s;

endpackage

`default_nettype wire

// File: byteRam.sv
`timescale 1ns/10ps
`default_nettype none
`include "memSubsystem_defs.svh"

module byteRam (
    input  logic                      clk,
    input  logic                      we,
    input  logic [`MEM_ADDR_BITS-1:0] addr,
    input  logic [7:0]                wdata,
    output logic [7:0]                rdata
);

    logic [7:0] mem [0:`MEM_DEPTH-1];

    // contents start at zero in simulation
    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // old contents on a write cycle
    end

endmodule

`default_nettype wire

// File: dataPort.sv
`timescale 1ns/10ps
`default_nettype none

module dataPort (
    input  logic              clk,
    input  logic              rst,
    input  logic              lsuEn,
    input  memPkg::lsuReq_s   lsuReq,
    output logic              lsuReady,
    output logic              lsuDone,
    output memPkg::lsuResp_s  lsuResp,
    output memPkg::memReq_s   memReqOut,
    output logic              req,
    input  logic              ack,
    input  memPkg::dataWord_u ackData
);

    memPkg::lsuReq_s held;
    logic busy;
    logic accept;
    logic finish;

    assign accept = lsuEn && lsuReady;
    assign finish = req && ack;

    // free again once the controller has dropped ack
    assign lsuReady = !busy || (!req && !ack);

    assign memReqOut = held.mem;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            req <= 1'b0;
            lsuDone <= 1'b0;
        end else begin
            lsuDone <= finish;
            if (accept) begin
                busy <= 1'b1;
                req <= 1'b1;
            end else if (finish) begin
                req <= 1'b0; // second phase of the handshake
            end else if (!req && !ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= lsuReq;
        end
        if (finish) begin
            lsuResp.tag <= held.tag;
            lsuResp.data.word <= held.mem.store ? '0 : ackData.word; // stores report zero
        end
    end

endmodule

`default_nettype wire

// File: fetchPort.sv
`timescale 1ns/10ps
`default_nettype none
`include "memSubsystem_defs.svh"

module fetchPort (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetchEn,
    input  logic [`MEM_ADDR_BITS-1:0] fetchAddr,
    output logic                      fetchReady,
    output logic                      fetchDone,
    output memPkg::dataWord_u         fetchData,
    output memPkg::memReq_s           memReqOut,
    output logic                      req,
    input  logic                      ack,
    input  memPkg::dataWord_u         ackData
);

    logic [`MEM_ADDR_BITS-1:0] heldAddr;
    logic busy;
    logic accept;
    logic finish;

    assign accept = fetchEn && fetchReady;
    assign finish = req && ack;
    assign fetchReady = !busy || (!req && !ack);

    // every fetch is a full word load, alignment is the front end's job
    always_comb begin
        memReqOut = '0;
        memReqOut.store = 1'b0;
        memReqOut.addr = heldAddr;
        memReqOut.len = memPkg::LEN_WORD;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            req <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= finish;
            if (accept) begin
                busy <= 1'b1;
                req <= 1'b1;
            end else if (finish) begin
                req <= 1'b0;
            end else if (!req && !ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldAddr <= fetchAddr;
        end
        if (finish) begin
            fetchData <= ackData;
        end
    end

endmodule

`default_nettype wire

// File: memCtrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "memSubsystem_defs.svh"

module memCtrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dReq,
    input  memPkg::memReq_s           dReqData,
    output logic                      dAck,
    input  logic                      fReq,
    input  memPkg::memReq_s           fReqData,
    output logic                      fAck,
    output memPkg::dataWord_u         rdData,
    output logic                      ramWe,
    output logic [`MEM_ADDR_BITS-1:0] ramAddr,
    output logic [7:0]                ramWdata,
    input  logic [7:0]                ramRdata
);

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        ACKING = 2'd2
    } ctrlState_e;

    ctrlState_e state;
    logic gntData; // also remembers who was served last
    logic pickData;
    logic anyReq;
    logic gntReq;
    memPkg::memReq_s selReq;
    memPkg::memReq_s cur;
    logic [2:0] cnt;
    logic [2:0] endCnt;
    logic [1:0] loadLane;
    memPkg::dataWord_u collect;

    function automatic logic [2:0] lenBytes(input memPkg::accLen_e len);
        case (len)
            memPkg::LEN_BYTE: lenBytes = 3'd1;
            memPkg::LEN_HALF: lenBytes = 3'd2;
            default: lenBytes = 3'(`WORD_BYTES);
        endcase
    endfunction

    assign anyReq = dReq || fReq;

    // on a tie the port not served last wins
    assign pickData = dReq && (!fReq || !gntData);
    assign selReq = pickData ? dReqData : fReqData;
    assign gntReq = gntData ? dReq : fReq;

    assign dAck = (state == ACKING) && gntData;
    assign fAck = (state == ACKING) && !gntData;
    assign rdData = collect;

    // byte order is little endian, the address wraps at the RAM size
    assign ramWe = (state == RUN) && cur.store;
    assign ramAddr = cur.addr + `MEM_ADDR_BITS'(cnt);
    assign ramWdata = cur.data.lane[cnt[1:0]];

    // read data lags the address by one cycle
    assign loadLane = cnt[1:0] - 2'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            gntData <= 1'b1; // so the fetch port wins the first tie
            cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (anyReq) begin
                        state <= RUN;
                        gntData <= pickData;
                        cnt <= '0;
                    end
                end
                RUN: begin
                    cnt <= cnt + 3'd1;
                    if (cnt == endCnt) begin
                        state <= ACKING;
                    end
                end
                ACKING: begin
                    if (!gntReq) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && anyReq) begin
            cur <= selReq;
            // loads need one more cycle for the last byte to come back
            endCnt <= lenBytes(selReq.len) - (selReq.store ? 3'd1 : 3'd0);
            collect <= '0;
        end else if (state == RUN && !cur.store && cnt != 3'd0) begin
            collect.lane[loadLane] <= ramRdata;
        end
    end

endmodule

`default_nettype wire

// File: memSubsystem.sv
`timescale 1ns/10ps
`default_nettype none
`include "memSubsystem_defs.svh"

module memSubsystem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      lsuEn,
    input  memPkg::lsuReq_s           lsuReq,
    output logic                      lsuReady,
    output logic                      lsuDone,
    output memPkg::lsuResp_s          lsuResp,
    input  logic                      fetchEn,
    input  logic [`MEM_ADDR_BITS-1:0] fetchAddr,
    output logic                      fetchReady,
    output logic                      fetchDone,
    output memPkg::dataWord_u         fetchData
);

    memPkg::memReq_s dMemReq;
    memPkg::memReq_s fMemReq;
    memPkg::dataWord_u rdData; // shared by both ports
    logic dReq;
    logic dAck;
    logic fReq;
    logic fAck;
    logic ramWe;
    logic [`MEM_ADDR_BITS-1:0] ramAddr;
    logic [7:0] ramWdata;
    logic [7:0] ramRdata;

    dataPort dataPortInst (
        .clk(clk), .rst(rst),
        .lsuEn(lsuEn), .lsuReq(lsuReq), .lsuReady(lsuReady),
        .lsuDone(lsuDone), .lsuResp(lsuResp),
        .memReqOut(dMemReq), .req(dReq), .ack(dAck), .ackData(rdData)
    );

    fetchPort fetchPortInst (
        .clk(clk), .rst(rst),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr), .fetchReady(fetchReady),
        .fetchDone(fetchDone), .fetchData(fetchData),
        .memReqOut(fMemReq), .req(fReq), .ack(fAck), .ackData(rdData)
    );

    memCtrl memCtrlInst (
        .clk(clk), .rst(rst),
        .dReq(dReq), .dReqData(dMemReq), .dAck(dAck),
        .fReq(fReq), .fReqData(fMemReq), .fAck(fAck),
        .rdData(rdData),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

    byteRam byteRamInst (
        .clk(clk), .we(ramWe), .addr(ramAddr), .wdata(ramWdata), .rdata(ramRdata)
    );

endmodule

`default_nettype wire

// File: memSubsystemChecker.sv
`timescale 1ns/10ps
`default_nettype none
`include "memSubsystem_defs.svh"

module memSubsystemChecker (
    input logic              clk,
    input logic              rst,
    input logic              lsuReady,
    input logic              lsuDone,
    input memPkg::lsuResp_s  lsuResp,
    input logic              fetchReady,
    input logic              fetchDone,
    input memPkg::dataWord_u fetchData
);

    logic [`TAG_BITS-1:0] tagQ [$];
    memPkg::dataWord_u loadQ [$];
    memPkg::dataWord_u fetchQ [$];
    int valueErrors = 0;
    int otherErrors = 0;
    logic resetSeen = 1'b0;

    task automatic postData(input logic [`TAG_BITS-1:0] tag, input memPkg::dataWord_u data);
        tagQ.push_back(tag);
        loadQ.push_back(data);
    endtask

    task automatic postFetch(input memPkg::dataWord_u data);
        fetchQ.push_back(data);
    endtask

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic reportProblem(input string what);
        $display("error at %0t: %s", $time, what);
        otherErrors++;
    endtask

    task automatic reportLeftovers();
        if (tagQ.size() != 0) begin
            reportProblem($sformatf("%0d data port requests never saw lsuDone", tagQ.size()));
        end
        if (fetchQ.size() != 0) begin
            reportProblem($sformatf("%0d fetches never saw fetchDone", fetchQ.size()));
        end
    endtask

    // outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst && !resetSeen) begin
            resetSeen = 1'b1;
            if (lsuDone || fetchDone) begin
                reportProblem("a Done output is high right after reset");
            end
            if (!lsuReady || !fetchReady) begin
                reportProblem("a Ready output is low right after reset");
            end
        end
        if (!rst && lsuDone) begin
            if (lsuReady) begin
                reportProblem("lsuReady is high while lsuDone pulses");
            end
            if (tagQ.size() == 0) begin
                reportProblem("lsuDone pulsed with no data request outstanding");
            end else begin
                compareValue("lsuResp.tag", 32'(tagQ.pop_front()), 32'(lsuResp.tag));
                compareValue("lsuResp.data", loadQ.pop_front(), lsuResp.data.word);
            end
        end
        if (!rst && fetchDone) begin
            if (fetchReady) begin
                reportProblem("fetchReady is high while fetchDone pulses");
            end
            if (fetchQ.size() == 0) begin
                reportProblem("fetchDone pulsed with no fetch outstanding");
            end else begin
                compareValue("fetchData", fetchQ.pop_front(), fetchData.word);
            end
        end
    end

endmodule

`default_nettype wire

// File: memSubsystemTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "memSubsystem_defs.svh"

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

endmodule

module memSubsystemTb;

    localparam int NUM_OPS = 300;
    localparam int CYCLE_LIMIT = NUM_OPS * 12 + 1000;
    localparam logic [31:0] LFSR_SEED = 32'd77681;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam logic [`MEM_ADDR_BITS-1:0] WINDOW_BASE = `MEM_ADDR_BITS'('h3E0); // wraps at the top

    logic clk;
    logic rst;
    logic lsuEn;
    memPkg::lsuReq_s lsuReq;
    logic lsuReady;
    logic lsuDone;
    memPkg::lsuResp_s lsuResp;
    logic fetchEn;
    logic [`MEM_ADDR_BITS-1:0] fetchAddr;
    logic fetchReady;
    logic fetchDone;
    memPkg::dataWord_u fetchData;

    logic [7:0] model [0:`MEM_DEPTH-1];
    logic [31:0] lfsrState;
    memPkg::lsuReq_s nextReq;
    memPkg::memReq_s lastData;
    logic [`MEM_ADDR_BITS-1:0] nextAddr;
    logic [`MEM_ADDR_BITS-1:0] lastFetchAddr;
    logic [31:0] pick;
    logic doData;
    logic doFetch;
    int issued;
    int totalErrors;
    int cycleCount = 0;

    tbClock clockInst (.clk(clk));

    memSubsystem memSubsystem_inst (
        .clk(clk), .rst(rst),
        .lsuEn(lsuEn), .lsuReq(lsuReq), .lsuReady(lsuReady),
        .lsuDone(lsuDone), .lsuResp(lsuResp),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr), .fetchReady(fetchReady),
        .fetchDone(fetchDone), .fetchData(fetchData)
    );

    memSubsystemChecker checkInst (
        .clk(clk), .rst(rst),
        .lsuReady(lsuReady), .lsuDone(lsuDone), .lsuResp(lsuResp),
        .fetchReady(fetchReady), .fetchDone(fetchDone), .fetchData(fetchData)
    );

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] drawBits(input int n);
        logic [31:0] bits;
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
        return bits;
    endfunction

    function automatic int byteCount(input memPkg::accLen_e len);
        case (len)
            memPkg::LEN_BYTE: return 1;
            memPkg::LEN_HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // byte ranges compared with the same wrap as the RAM address
    function automatic logic overlaps(input logic [`MEM_ADDR_BITS-1:0] a, input int aLen,
                                      input logic [`MEM_ADDR_BITS-1:0] b, input int bLen);
        int i;
        int j;
        for (i = 0; i < aLen; i++) begin
            for (j = 0; j < bLen; j++) begin
                if (a + `MEM_ADDR_BITS'(i) == b + `MEM_ADDR_BITS'(j)) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    function automatic logic canIssue();
        logic ok;
        ok = (!doData || lsuReady) && (!doFetch || fetchReady);
        if (doData && nextReq.mem.store && !fetchReady &&
            overlaps(nextReq.mem.addr, byteCount(nextReq.mem.len), lastFetchAddr, 4)) begin
            ok = 1'b0; // a store must not race a fetch of the same bytes
        end
        if (doFetch && !lsuReady && lastData.store &&
            overlaps(lastData.addr, byteCount(lastData.len), nextAddr, 4)) begin
            ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic issueData(input memPkg::lsuReq_s r);
        memPkg::dataWord_u expected;
        logic [`MEM_ADDR_BITS-1:0] a;
        int i;
        expected = '0; // loads are zero-extended and stores report zero
        for (i = 0; i < byteCount(r.mem.len); i++) begin
            a = r.mem.addr + `MEM_ADDR_BITS'(i);
            if (r.mem.store) begin
                model[a] = r.mem.data.lane[i];
            end else begin
                expected.lane[i] = model[a];
            end
        end
        lsuReq = r;
        lsuEn = 1'b1;
        lastData = r.mem;
        checkInst.postData(r.tag, expected);
    endtask

    task automatic issueFetch(input logic [`MEM_ADDR_BITS-1:0] addr);
        memPkg::dataWord_u expected;
        int i;
        for (i = 0; i < 4; i++) begin
            expected.lane[i] = model[addr + `MEM_ADDR_BITS'(i)];
        end
        fetchAddr = addr;
        fetchEn = 1'b1;
        lastFetchAddr = addr;
        checkInst.postFetch(expected);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        lsuEn = 1'b0;
        lsuReq = '0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        lastData = '0;
        lastFetchAddr = '0;
        nextReq = '0;
        nextAddr = '0;
        lfsrState = LFSR_SEED;
        for (int k = 0; k < `MEM_DEPTH; k++) begin
            model[k] = 8'h00;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        issued = 0;
        while (issued < NUM_OPS) begin
            @(negedge clk);
            lsuEn = 1'b0;
            fetchEn = 1'b0;
            pick = drawBits(2);
            doData = (pick[1:0] != 2'd1);
            doFetch = (pick[1:0] != 2'd0);
            nextReq.mem.store = 1'(drawBits(1));
            pick = drawBits(2);
            nextReq.mem.len = (pick[1:0] == 2'd3) ? memPkg::LEN_WORD : memPkg::accLen_e'(pick[1:0]);
            nextReq.mem.addr = WINDOW_BASE + `MEM_ADDR_BITS'(drawBits(6));
            nextReq.mem.data.word = drawBits(32);
            nextReq.tag = `TAG_BITS'(drawBits(`TAG_BITS));
            nextAddr = WINDOW_BASE + `MEM_ADDR_BITS'(drawBits(4) * 4);
            if (doData && doFetch && nextReq.mem.store &&
                overlaps(nextReq.mem.addr, byteCount(nextReq.mem.len), nextAddr, 4)) begin
                doFetch = 1'b0; // arbitration order would decide the fetch result
            end
            while (!canIssue()) begin
                @(negedge clk);
            end
            if (doData) begin
                issueData(nextReq);
                issued++;
            end
            if (doFetch) begin
                issueFetch(nextAddr);
                issued++;
            end
        end
        @(negedge clk);
        lsuEn = 1'b0;
        fetchEn = 1'b0;
        while (!(lsuReady && fetchReady)) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        checkInst.reportLeftovers();
        totalErrors = checkInst.valueErrors + checkInst.otherErrors;
        $display("%0d operations, %0d wrong values, %0d other errors",
                 issued, checkInst.valueErrors, checkInst.otherErrors);
        if (totalErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: memSubsystem.f
+incdir+.
memPkg.sv
byteRam.sv
dataPort.sv
fetchPort.sv
memCtrl.sv
memSubsystem.sv
memSubsystemChecker.sv
memSubsystemTb.sv

// File: Bender.yml
package:
  name: memsubsystem

sources:
  - include_dirs:
      - .
    files:
      - memPkg.sv
      - byteRam.sv
      - dataPort.sv
      - fetchPort.sv
      - memCtrl.sv
      - memSubsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - memSubsystemChecker.sv
      - memSubsystemTb.sv
